// File: Bender.yml
package:
  name: sv32_mmu

sources:
  # Packages first, then the RTL bottom up
  - design/sv32_pkg.sv
  - design/mmu_pkg.sv
  - design/sv32_tlb.sv
  - design/sv32_perm_check.sv
  - design/sv32_walker.sv
  - design/sv32_mmu.sv

  # Testbench, top module mmu_tb
  - target: test
    files:
      - sim/mmu_tb.sv

// File: compile.f
design/sv32_pkg.sv
design/mmu_pkg.sv
design/sv32_tlb.sv
design/sv32_perm_check.sv
design/sv32_walker.sv
design/sv32_mmu.sv
sim/mmu_tb.sv

// File: design/mmu_pkg.sv
// MMU implementation types for the Sv32 data-side MMU
// Only load and store page faults are reported, no fetch side
// M mode is always bare, so priv_e M never reaches the permission check
package mmu_pkg;

    import sv32_pkg::*;

    // ==============================
    // Encodings
    // ==============================

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    // mcause/scause values for data page faults
    typedef enum logic [3:0] {
        LOAD_PAGE_FAULT  = 4'd13,
        STORE_PAGE_FAULT = 4'd15
    } fault_cause_e;

    // ==============================
    // Structs between blocks
    // ==============================

    // Core request, held until ready or fault
    typedef struct packed {
        vaddr_t vaddr;
        logic   is_store;
    } xlat_req_t;

    // CSR levels from the core
    typedef struct packed {
        satp_t satp;
        priv_e priv;
        logic  sum;
        logic  mxr;
    } csr_ctrl_t;

    // Translation result as stored in the TLB
    // superpage set means a level-1 leaf, ppn[9:0] then unused
    typedef struct packed {
        ppn_t       ppn;
        pte_flags_t flags;
        logic       superpage;
    } leaf_t;

endpackage

// File: design/sv32_mmu.sv
// Sv32 data-side MMU top level
// Bare when satp.MODE is 0 or in M mode, ready then follows req directly
// Core holds req and xlat until ready or fault, sfence only while req is low
// A successful walk refills the TLB even when the permission check faults
`timescale 1ns/1ns

module sv32_mmu
    import sv32_pkg::*;
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         req,
    input  xlat_req_t    xlat,
    input  csr_ctrl_t    csr,
    input  logic         sfence,
    input  pte_t         mem_rdata,
    input  logic         mem_ready,
    output logic         ready,
    output logic         fault,
    output paddr_t       paddr,
    output fault_cause_e fault_cause,
    output logic         mem_req,
    output paddr_t       mem_addr
);

    // Offset bits kept from the vaddr on a superpage
    localparam int SUPER_OFF_W = PAGE_OFFSET_W + $bits(vpn_t);

    logic   vm_active;
    logic   lookup_en;
    logic   tlb_hit;
    leaf_t  tlb_leaf;
    logic   walk_start;
    logic   walk_done;
    logic   walk_err;
    leaf_t  walk_leaf;
    vaddr_t walk_vaddr;
    logic   busy_q;
    leaf_t  chk_leaf;
    logic   leaf_avail;
    logic   perm_fault;

    // ==============================
    // Mode and miss handling
    // ==============================

    assign vm_active  = csr.satp.mode && (csr.priv != PRIV_M);
    assign lookup_en  = req && vm_active;
    // Walk on a miss, one at a time
    assign walk_start = lookup_en && !tlb_hit && !busy_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (walk_start) begin
            busy_q <= 1'b1;
        end else if (walk_done) begin
            busy_q <= 1'b0;
        end
    end

    sv32_tlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) tlb0 (
        .clk         (clk),
        .rst         (rst),
        .lookup_en   (lookup_en),
        .lookup_vaddr(xlat.vaddr),
        .refill      (walk_done && !walk_err),
        .refill_vaddr(walk_vaddr),
        .refill_leaf (walk_leaf),
        .flush       (sfence),
        .hit         (tlb_hit),
        .hit_leaf    (tlb_leaf)
    );

    sv32_walker walker0 (
        .clk       (clk),
        .rst       (rst),
        .start     (walk_start),
        .vaddr     (xlat.vaddr),
        .root_ppn  (csr.satp.ppn),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .done      (walk_done),
        .walk_err  (walk_err),
        .leaf      (walk_leaf),
        .walk_vaddr(walk_vaddr)
    );

    // ==============================
    // Check and response
    // ==============================

    // Walker result only in its done cycle, TLB misses then anyway
    assign chk_leaf   = walk_done ? walk_leaf : tlb_leaf;
    assign leaf_avail = tlb_hit || (walk_done && !walk_err);

    sv32_perm_check perm0 (
        .leaf      (chk_leaf),
        .is_store  (xlat.is_store),
        .csr       (csr),
        .perm_fault(perm_fault)
    );

    assign ready = req && (!vm_active || (leaf_avail && !perm_fault));
    assign fault = lookup_en && ((leaf_avail && perm_fault) || (walk_done && walk_err));

    // Bare zero-extends, superpage keeps 22 offset bits
    always_comb begin
        if (!vm_active) begin
            paddr = {2'b00, xlat.vaddr};
        end else if (chk_leaf.superpage) begin
            paddr = {chk_leaf.ppn[$bits(ppn_t)-1:$bits(vpn_t)], xlat.vaddr[SUPER_OFF_W-1:0]};
        end else begin
            paddr = {chk_leaf.ppn, xlat.vaddr[PAGE_OFFSET_W-1:0]};
        end
    end

    assign fault_cause = xlat.is_store ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;

endmodule

// File: design/sv32_perm_check.sv
// Leaf permission check for data accesses, purely combinational
// A clear A bit, or a clear D bit on a store, faults (no hardware A/D update)
// M mode is never checked here since it is always bare
`timescale 1ns/1ns

module sv32_perm_check
    import sv32_pkg::*;
    import mmu_pkg::*;
(
    input  leaf_t     leaf,
    input  logic      is_store,
    input  csr_ctrl_t csr,
    output logic      perm_fault
);

    pte_flags_t f;
    logic       load_ok;
    logic       store_ok;
    logic       priv_ok;

    assign f = leaf.flags;

    // MXR lets loads read execute-only pages
    assign load_ok  = f.r || (csr.mxr && f.x);
    assign store_ok = f.w && f.d;

    // U pages for U mode, S mode needs SUM to touch them
    always_comb begin
        case (csr.priv)
            PRIV_U:  priv_ok = f.u;
            PRIV_S:  priv_ok = !f.u || csr.sum;
            default: priv_ok = 1'b1;
        endcase
    end

    assign perm_fault = !f.a || !priv_ok || (is_store ? !store_ok : !load_ok);

endmodule

// File: design/sv32_pkg.sv
// Sv32 architectural types shared by the MMU and its testbench
// Covers the 32-bit virtual and 34-bit physical address split only
// PTE flags are kept as their own struct so a leaf can carry them unchanged
package sv32_pkg;

    // ==============================
    // Widths
    // ==============================

    // Virtual address, VPN[1] | VPN[0] | offset
    typedef logic [31:0] vaddr_t;

    // Physical address out of the MMU
    typedef logic [33:0] paddr_t;

    // Physical page number, also the table base
    typedef logic [21:0] ppn_t;

    // VPN of a single level
    typedef logic [9:0]  vpn_t;

    localparam int PAGE_OFFSET_W = 12;
    localparam int PTE_BYTES     = 4;

    // ==============================
    // PTE and satp layout
    // ==============================

    // Low ten bits of a PTE, RSW down to V
    typedef struct packed {
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_flags_t;

    typedef struct packed {
        ppn_t       ppn;
        pte_flags_t flags;
    } pte_t;

    // MODE set selects Sv32, ASID carried but not matched
    typedef struct packed {
        logic       mode;
        logic [8:0] asid;
        ppn_t       ppn;
    } satp_t;

    // VPN field extraction
    function automatic vpn_t vpn1_of(input vaddr_t va);
        return va[31:22];
    endfunction

    function automatic vpn_t vpn0_of(input vaddr_t va);
        return va[21:12];
    endfunction

endpackage

// File: design/sv32_tlb.sv
// Fully associative TLB with round-robin replacement
// Lookup is combinational, refill and flush land on the next edge
// No ASID tag, so every flush clears the whole array
// Expects one refill per miss, so duplicate entries are never created
`timescale 1ns/1ns

module sv32_tlb
    import sv32_pkg::*;
    import mmu_pkg::*;
#(
    parameter int TLB_ENTRIES = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   lookup_en,
    input  vaddr_t lookup_vaddr,
    input  logic   refill,
    input  vaddr_t refill_vaddr,
    input  leaf_t  refill_leaf,
    input  logic   flush,
    output logic   hit,
    output leaf_t  hit_leaf
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    typedef logic [IDX_W-1:0] tlb_idx_t;

    // ==============================
    // Storage
    // ==============================

    logic [TLB_ENTRIES-1:0] valid_q;
    vpn_t                   tag_vpn1_q [TLB_ENTRIES];
    vpn_t                   tag_vpn0_q [TLB_ENTRIES];
    leaf_t                  leaf_q     [TLB_ENTRIES];
    tlb_idx_t               rr_ptr_q;

    logic [TLB_ENTRIES-1:0] match;
    vpn_t                   look_vpn1;
    vpn_t                   look_vpn0;

    assign look_vpn1 = vpn1_of(lookup_vaddr);
    assign look_vpn0 = vpn0_of(lookup_vaddr);

    // ==============================
    // Lookup
    // ==============================

    // Superpage entries ignore VPN[0]
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = valid_q[i] && (tag_vpn1_q[i] == look_vpn1) &&
                       (leaf_q[i].superpage || (tag_vpn0_q[i] == look_vpn0));
        end
    end

    // Lowest matching slot wins
    always_comb begin
        hit_leaf = leaf_q[0];
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_leaf = leaf_q[i];
            end
        end
    end

    assign hit = lookup_en && (|match);

    // ==============================
    // Refill and flush
    // ==============================

    // Valid bits and victim pointer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (refill) begin
            valid_q[rr_ptr_q] <= 1'b1;
            // Wrap for entry counts that are not a power of two
            if (rr_ptr_q == tlb_idx_t'(TLB_ENTRIES - 1)) begin
                rr_ptr_q <= '0;
            end else begin
                rr_ptr_q <= rr_ptr_q + 1'b1;
            end
        end
    end

    // Tag and leaf payload of the victim slot
    always_ff @(posedge clk) begin
        if (refill && !flush) begin
            tag_vpn1_q[rr_ptr_q] <= vpn1_of(refill_vaddr);
            tag_vpn0_q[rr_ptr_q] <= vpn0_of(refill_vaddr);
            leaf_q[rr_ptr_q]     <= refill_leaf;
        end
    end

endmodule

// File: design/sv32_walker.sv
// Two-level Sv32 page table walker, read only
// One walk at a time, start is ignored unless the FSM is idle
// mem_req and mem_addr are held until mem_ready, any latency works
// walk_err and leaf are valid only while done is high
`timescale 1ns/1ns

module sv32_walker
    import sv32_pkg::*;
    import mmu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  vaddr_t vaddr,
    input  ppn_t   root_ppn,
    input  pte_t   mem_rdata,
    input  logic   mem_ready,
    output logic   mem_req,
    output paddr_t mem_addr,
    output logic   done,
    output logic   walk_err,
    output leaf_t  leaf,
    output vaddr_t walk_vaddr
);

    typedef enum logic [1:0] {
        IDLE,
        L1,
        L0,
        DONE
    } walk_state_e;

    walk_state_e state_q;
    walk_state_e state_d;

    // Walk payload
    vaddr_t vaddr_q;
    ppn_t   table_ppn_q;
    leaf_t  leaf_q;
    logic   err_q;

    vpn_t   cur_vpn;
    paddr_t pte_offset;
    logic   pte_bad;
    logic   pte_leaf;
    logic   sp_misaligned;

    // ==============================
    // PTE address
    // ==============================

    assign cur_vpn    = (state_q == L1) ? vpn1_of(vaddr_q) : vpn0_of(vaddr_q);
    assign pte_offset = paddr_t'(cur_vpn) * paddr_t'(PTE_BYTES);
    assign mem_addr   = {table_ppn_q, {PAGE_OFFSET_W{1'b0}}} + pte_offset;
    assign mem_req    = (state_q == L1) || (state_q == L0);

    // ==============================
    // PTE decode
    // ==============================

    // Not valid, or the reserved W without R
    assign pte_bad       = !mem_rdata.flags.v || (mem_rdata.flags.w && !mem_rdata.flags.r);
    // R or X marks a leaf, otherwise a pointer
    assign pte_leaf      = mem_rdata.flags.r || mem_rdata.flags.x;
    // Superpage must be 4 MiB aligned
    assign sp_misaligned = vpn_t'(mem_rdata.ppn) != '0;

    // ==============================
    // FSM
    // ==============================

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = L1;
                end
            end
            L1: begin
                // Leaf or bad PTE ends the walk at level 1
                if (mem_ready) begin
                    state_d = (pte_bad || pte_leaf) ? DONE : L0;
                end
            end
            L0: begin
                if (mem_ready) begin
                    state_d = DONE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address capture and per-level result
    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                if (start) begin
                    vaddr_q     <= vaddr;
                    table_ppn_q <= root_ppn;
                end
            end
            L1: begin
                if (mem_ready) begin
                    // Pointer case reuses ppn as the next table base
                    table_ppn_q      <= mem_rdata.ppn;
                    leaf_q.ppn       <= mem_rdata.ppn;
                    leaf_q.flags     <= mem_rdata.flags;
                    leaf_q.superpage <= 1'b1;
                    err_q            <= pte_bad || (pte_leaf && sp_misaligned);
                end
            end
            L0: begin
                if (mem_ready) begin
                    leaf_q.ppn       <= mem_rdata.ppn;
                    leaf_q.flags     <= mem_rdata.flags;
                    leaf_q.superpage <= 1'b0;
                    // Pointer at level 0 is malformed
                    err_q            <= pte_bad || !pte_leaf;
                end
            end
            default: begin
            end
        endcase
    end

    assign done       = (state_q == DONE);
    assign walk_err   = err_q;
    assign leaf       = leaf_q;
    assign walk_vaddr = vaddr_q;

endmodule

// File: sim/mmu_tb.sv
// Testbench for the Sv32 data-side MMU
// Page tables live in a 64 KiB word array, PTE reads above it return zero
// Memory latency is a random 0 to 3 idle cycles per read
// Every access is checked against a software walk of the same tables
`timescale 1ns/1ns

module mmu_tb
    import sv32_pkg::*;
    import mmu_pkg::*;
;

    // ==============================
    // Constants
    // ==============================

    localparam int HALF         = 10;
    localparam int QUARTER      = 5;
    localparam int RESET_CYCLES = 16;
    localparam int MEM_WORDS    = 16384;
    localparam int N_PAIRS      = 8;
    localparam int N_MIXED      = 16;
    // Bare, pairs, superpage, permission, malformed, remap, mixed
    localparam int N_ACCESS     = 6 + 2 * N_PAIRS + 2 + 10 + 5 + 2 + N_MIXED;
    localparam int CYCLE_LIMIT  = N_ACCESS * 16 + RESET_CYCLES + 200;

    localparam ppn_t ROOT_PPN = 22'h00004;
    localparam ppn_t L0_PPN   = 22'h00005;

    // PTE flag bits
    localparam logic [9:0] F_V  = 10'h001;
    localparam logic [9:0] F_R  = 10'h002;
    localparam logic [9:0] F_W  = 10'h004;
    localparam logic [9:0] F_X  = 10'h008;
    localparam logic [9:0] F_U  = 10'h010;
    localparam logic [9:0] F_A  = 10'h040;
    localparam logic [9:0] F_D  = 10'h080;
    localparam logic [9:0] RWAD = F_V | F_R | F_W | F_A | F_D;

    // ==============================
    // DUT signals and bookkeeping
    // ==============================

    logic         clk;
    logic         rst;
    logic         req;
    xlat_req_t    xlat;
    csr_ctrl_t    csr;
    logic         sfence;
    pte_t         mem_rdata;
    logic         mem_ready;
    logic         ready;
    logic         fault;
    paddr_t       paddr;
    fault_cause_e fault_cause;
    logic         mem_req;
    paddr_t       mem_addr;

    logic [31:0] mem [MEM_WORDS];
    integer      stim_seed = 32'h6bef_f5d2;
    integer      lat_seed  = 32'h6bef_f5d2;
    int          reads;
    int          req_cycles;
    int          cycle_cnt;
    int          n_tests;
    int          n_passed;
    int          n_failed;
    int          check_errs;

    sv32_mmu #(
        .TLB_ENTRIES(4)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .xlat       (xlat),
        .csr        (csr),
        .sfence     (sfence),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .ready      (ready),
        .fault      (fault),
        .paddr      (paddr),
        .fault_cause(fault_cause),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF) clk = ~clk;
    end

    // ==============================
    // Memory and reference model
    // ==============================

    function automatic logic [31:0] read_word(input paddr_t a);
        if (a >= paddr_t'(MEM_WORDS * 4)) begin
            return 32'h0;
        end
        return mem[a[15:2]];
    endfunction

    function automatic logic [31:0] make_pte(input ppn_t ppn, input logic [9:0] flags);
        return {ppn, flags};
    endfunction

    task automatic set_pte(input ppn_t table_ppn, input int idx, input logic [31:0] pte);
        paddr_t a;
        a = {table_ppn, 12'h000} + paddr_t'(idx * 4);
        mem[a[15:2]] = pte;
    endtask

    // Software walk of the tables, follows the Sv32 rules directly
    function automatic void model_xlat(input vaddr_t va, input logic st, input csr_ctrl_t c,
                                       output logic flt, output paddr_t pa);
        pte_t pte;
        logic is_super;
        logic ok;
        pa  = {2'b00, va};
        flt = 1'b0;
        if (!c.satp.mode || c.priv == PRIV_M) begin
            return;
        end
        pte      = pte_t'(read_word({c.satp.ppn, 12'h000} + paddr_t'(va[31:22]) * 4));
        is_super = 1'b1;
        // Valid pointer at level 1, descend
        if (pte.flags.v && !pte.flags.r && !pte.flags.w && !pte.flags.x) begin
            pte      = pte_t'(read_word({pte.ppn, 12'h000} + paddr_t'(va[21:12]) * 4));
            is_super = 1'b0;
            if (!pte.flags.r && !pte.flags.x) begin
                flt = 1'b1;
            end
        end
        if (!pte.flags.v || (pte.flags.w && !pte.flags.r)) begin
            flt = 1'b1;
        end
        if (is_super && pte.ppn[9:0] != 10'h0) begin
            flt = 1'b1;
        end
        ok = pte.flags.a;
        if (c.priv == PRIV_U) begin
            ok &= pte.flags.u;
        end else begin
            ok &= !pte.flags.u || c.sum;
        end
        if (st) begin
            ok &= pte.flags.w && pte.flags.d;
        end else begin
            ok &= pte.flags.r || (c.mxr && pte.flags.x);
        end
        flt |= !ok;
        pa = is_super ? {pte.ppn[21:10], va[21:0]} : {pte.ppn, va[11:0]};
    endfunction

    // Table layout, root entries 1 to 4 and one level-0 table
    task automatic build_tables();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h0;
        end
        set_pte(ROOT_PPN, 1, make_pte(L0_PPN, F_V));
        set_pte(ROOT_PPN, 2, make_pte(22'h2a400, RWAD));
        // Misaligned superpage
        set_pte(ROOT_PPN, 3, make_pte(22'h2a401, RWAD));
        for (int i = 0; i < 8; i++) begin
            set_pte(L0_PPN, i, make_pte(22'h12300 + ppn_t'(i), RWAD));
        end
        set_pte(L0_PPN, 8, make_pte(22'h20008, RWAD | F_U));
        set_pte(L0_PPN, 9, make_pte(22'h20009, F_V | F_R | F_A | F_D));
        set_pte(L0_PPN, 10, make_pte(22'h2000a, F_V | F_R | F_W | F_D));
        set_pte(L0_PPN, 11, make_pte(22'h2000b, F_V | F_R | F_W | F_A));
        set_pte(L0_PPN, 12, make_pte(22'h2000c, F_V | F_X | F_A));
        // Entry 13 stays invalid
        set_pte(L0_PPN, 14, make_pte(22'h2000e, F_V | F_W | F_A | F_D));
        // Pointer at level 0
        set_pte(L0_PPN, 15, make_pte(22'h2000f, F_V));
    endtask

    // Read port, answers after a random delay and counts busy cycles
    initial begin : mem_responder
        int wait_cnt;
        wait_cnt  = -1;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            mem_ready = 1'b0;
            if (mem_req) begin
                req_cycles++;
                if (wait_cnt < 0) begin
                    wait_cnt = int'($unsigned($random(lat_seed)) % 4);
                end
                if (wait_cnt == 0) begin
                    mem_rdata = pte_t'(read_word(mem_addr));
                    mem_ready = 1'b1;
                    reads++;
                    wait_cnt  = -1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // ==============================
    // Stimulus helpers
    // ==============================

    function automatic int rand_below(input int n);
        return int'($unsigned($random(stim_seed)) % n);
    endfunction

    function automatic vaddr_t page_va(input int vpn1, input int vpn0);
        return {vpn_t'(vpn1), vpn_t'(vpn0), 12'(rand_below(4096))};
    endfunction

    task automatic set_csr(input logic mode, input priv_e p, input logic s, input logic x);
        @(negedge clk);
        csr.satp.mode = mode;
        csr.satp.asid = '0;
        csr.satp.ppn  = ROOT_PPN;
        csr.priv      = p;
        csr.sum       = s;
        csr.mxr       = x;
    endtask

    task automatic pulse_sfence();
        @(negedge clk);
        sfence = 1'b1;
        @(negedge clk);
        sfence = 1'b0;
    endtask

    // want_reads: -1 any, 0 same-cycle answer with no memory traffic
    task automatic run_access(input string name, input vaddr_t va, input logic st,
                              input int want_reads);
        logic         exp_fault;
        paddr_t       exp_pa;
        logic [3:0]   exp_cause;
        logic         got_ready;
        logic         got_fault;
        paddr_t       got_pa;
        fault_cause_e got_cause;
        int           lat;
        int           n_reads;
        int           n_req;
        int           errs0;
        model_xlat(va, st, csr, exp_fault, exp_pa);
        // Store page fault 15, load page fault 13
        exp_cause = st ? 4'd15 : 4'd13;
        errs0     = check_errs;
        @(negedge clk);
        xlat.vaddr    = va;
        xlat.is_store = st;
        req           = 1'b1;
        #(QUARTER);
        n_reads = reads;
        n_req   = req_cycles;
        lat     = 0;
        while (!ready && !fault) begin
            @(negedge clk);
            #(QUARTER);
            lat++;
        end
        got_ready = ready;
        got_fault = fault;
        got_pa    = paddr;
        got_cause = fault_cause;
        n_reads   = reads - n_reads;
        // Core drops req in the cycle after the answer
        @(negedge clk);
        req = 1'b0;
        #(QUARTER);
        n_req = req_cycles - n_req;

        if (exp_fault) begin
            assert (got_fault && !got_ready) else begin
                $display("ERROR %s: fault got %h exp 1, va %h", name, got_fault, va);
                check_errs++;
            end
            assert (got_cause == exp_cause) else begin
                $display("ERROR %s: fault_cause got %h exp %h", name, got_cause, exp_cause);
                check_errs++;
            end
        end else begin
            assert (got_ready && !got_fault) else begin
                $display("ERROR %s: ready got %h exp 1, va %h", name, got_ready, va);
                check_errs++;
            end
            assert (got_pa == exp_pa) else begin
                $display("ERROR %s: paddr got %h exp %h", name, got_pa, exp_pa);
                check_errs++;
            end
        end
        if (want_reads == 0) begin
            assert (lat == 0 && n_req == 0) else begin
                $display("%s: answer came %0d cycles late or memory was requested", name, lat);
                check_errs++;
            end
        end else if (want_reads > 0) begin
            assert (n_reads == want_reads) else begin
                $display("%s: made %0d memory reads instead of %0d", name, n_reads, want_reads);
                check_errs++;
            end
        end
        n_tests++;
        if (check_errs == errs0) begin
            n_passed++;
        end else begin
            n_failed++;
        end
        $display("test %0d %-16s va %h: %s", n_tests, name, va,
                 (check_errs == errs0) ? "ok" : "mismatch");
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin : stimulus
        int vpn0;
        rst    = 1'b1;
        req    = 1'b0;
        xlat   = '0;
        csr    = '0;
        sfence = 1'b0;
        build_tables();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Bare mode, by satp and by M mode
        set_csr(1'b0, PRIV_S, 1'b0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            run_access("bare satp", vaddr_t'($random(stim_seed)), rand_below(2) == 1, 0);
        end
        set_csr(1'b1, PRIV_M, 1'b0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            run_access("bare M mode", vaddr_t'($random(stim_seed)), rand_below(2) == 1, 0);
        end

        // 4 KiB pages, second access in the same page must hit
        set_csr(1'b1, PRIV_S, 1'b0, 1'b0);
        for (int i = 0; i < N_PAIRS; i++) begin
            vpn0 = rand_below(8);
            run_access("page", page_va(1, vpn0), rand_below(2) == 1, -1);
            run_access("page hit", page_va(1, vpn0), rand_below(2) == 1, 0);
        end

        // Superpage, one read after a flush
        pulse_sfence();
        run_access("superpage", page_va(2, rand_below(1024)), 1'b0, 1);
        run_access("superpage hit", page_va(2, rand_below(1024)), 1'b1, 0);

        // Permission faults
        run_access("U page from S", page_va(1, 8), 1'b0, -1);
        set_csr(1'b1, PRIV_S, 1'b1, 1'b0);
        run_access("U page with SUM", page_va(1, 8), 1'b1, -1);
        set_csr(1'b1, PRIV_S, 1'b0, 1'b0);
        run_access("store no W", page_va(1, 9), 1'b1, -1);
        run_access("load no W", page_va(1, 9), 1'b0, -1);
        run_access("A clear", page_va(1, 10), 1'b0, -1);
        run_access("store D clear", page_va(1, 11), 1'b1, -1);
        run_access("load D clear", page_va(1, 11), 1'b0, -1);
        run_access("X only no MXR", page_va(1, 12), 1'b0, -1);
        set_csr(1'b1, PRIV_S, 1'b0, 1'b1);
        run_access("X only MXR", page_va(1, 12), 1'b0, -1);
        set_csr(1'b1, PRIV_U, 1'b0, 1'b0);
        run_access("S page from U", page_va(1, 0), 1'b0, -1);

        // Malformed tables
        set_csr(1'b1, PRIV_S, 1'b0, 1'b0);
        run_access("V clear", page_va(1, 13), 1'b0, -1);
        run_access("W without R", page_va(1, 14), 1'b1, -1);
        run_access("misaligned super", page_va(3, rand_below(1024)), 1'b0, -1);
        run_access("root invalid", page_va(4, rand_below(1024)), 1'b1, -1);
        run_access("pointer at L0", page_va(1, 15), 1'b0, -1);

        // Remap a page, the flush forces a fresh walk
        run_access("before remap", page_va(1, 2), 1'b0, -1);
        set_pte(L0_PPN, 2, make_pte(22'h3beef, RWAD));
        pulse_sfence();
        run_access("after remap", page_va(1, 2), 1'b1, 2);

        // Mixed random accesses over every mapping
        for (int i = 0; i < N_MIXED; i++) begin
            set_csr(1'b1, (rand_below(2) == 1) ? PRIV_U : PRIV_S,
                    rand_below(2) == 1, rand_below(2) == 1);
            run_access("mixed", page_va(1 + rand_below(4), rand_below(16)),
                       rand_below(2) == 1, -1);
        end

        $display("tests %0d, passed %0d, failed %0d", n_tests, n_passed, n_failed);
        if (n_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Run limit in cycles
    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the MMU stopped answering", cycle_cnt);
        $display("** FAIL **");
        $finish;
    end

endmodule
